//--- hw/z8CorePkg.sv
package z8CorePkg;

    typedef logic [7:0] byteT;
    typedef logic [15:0] addrT;
    typedef logic [7:0] regAddrT;
    typedef logic [3:0] nibbleT;

    // Fetch progress through the current instruction
    typedef enum logic [1:0] {
        fsIdle,
        fsByteOne,
        fsByteTwo,
        fsByteThree
    } fetchStateT;

    // Register pointer lives in the control register space
    localparam regAddrT regPtrAddr = 8'hFD;

    // High nibble E selects a working register
    localparam nibbleT workingPrefix = 4'hE;

endpackage

//--- hw/z8IsaPkg.sv
package z8IsaPkg;

    typedef logic [3:0] flagsT;

    // Flag bit positions
    localparam int flagC = 3;
    localparam int flagZ = 2;
    localparam int flagS = 1;
    localparam int flagV = 0;

    // ALU codes follow the opcode high nibble where one exists
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opAdc = 4'h1,
        opSub = 4'h2,
        opSbc = 4'h3,
        opOr  = 4'h4,
        opAnd = 4'h5,
        opTcm = 4'h6,
        opTm  = 4'h7,
        opLd  = 4'h8,
        opCp  = 4'hA,
        opXor = 4'hB,
        opRcf = 4'hC,
        opScf = 4'hD,
        opCcf = 4'hE
    } aluOpT;

    typedef logic [3:0] condT;

    // Opcode low nibbles
    localparam logic [3:0] lnRegReg = 4'h2;
    localparam logic [3:0] lnRegImm = 4'h6;
    localparam logic [3:0] lnLdRR   = 4'h8;
    localparam logic [3:0] lnJr     = 4'hB;
    localparam logic [3:0] lnLdImm  = 4'hC;
    localparam logic [3:0] lnJp     = 4'hD;
    localparam logic [3:0] lnMisc   = 4'hF;

    // Full opcodes outside the nibble groups
    localparam logic [7:0] codeSrp      = 8'h31;
    localparam logic [7:0] codeLdRegImm = 8'hE6;

endpackage

//--- hw/z8StageIf.sv
// Fetch to decode
interface instrIf
    import z8CorePkg::*;
();
    logic valid;
    logic ready;
    byteT opcode;
    byteT second;
    byteT third;
    addrT nextPc;

    modport source(output valid, output opcode, output second, output third,
                   output nextPc, input ready);
    modport sink(input valid, input opcode, input second, input third,
                 input nextPc, output ready);
endinterface

// Decode to execute
interface execIf
    import z8CorePkg::*;
    import z8IsaPkg::*;
();
    logic valid;
    logic ready;
    aluOpT op;
    byteT a;
    byteT b;
    regAddrT dst;

    modport source(output valid, output op, output a, output b, output dst,
                   input ready);
    modport sink(input valid, input op, input a, input b, input dst,
                 output ready);
endinterface

//--- hw/z8Fetch.sv
module z8Fetch
    import z8CorePkg::*;
    import z8IsaPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    output addrT   memAddr,
    output logic   memRead,
    input  byteT   memData,
    input  logic   redirect,
    input  addrT   target,
    instrIf.source instr
);

    fetchStateT state;
    addrT pc;
    logic held;
    logic taken;
    byteT opcode;
    byteT second;
    byteT third;
    logic [1:0] lenFirst;
    logic [1:0] lenHeld;

    function automatic logic [1:0] instrLength(byteT op);
        nibbleT lo;
        lo = op[3:0];
        if (lo[3:1] == 3'b111) begin
            return 2'd1;
        end
        if (lo[3:2] == 2'b01 || lo == lnJp) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    assign taken = held && instr.ready;
    // First byte is still on the bus in fsByteOne
    assign lenFirst = instrLength(memData);
    assign lenHeld = instrLength(opcode);
    assign memAddr = pc;

    always_comb begin
        case (state)
            fsIdle:    memRead = !held || taken;
            fsByteOne: memRead = lenFirst != 2'd1;
            fsByteTwo: memRead = lenHeld == 2'd3;
            default:   memRead = 1'b0;
        endcase
        // Nothing is read from the old stream once a branch is taken
        if (redirect) begin
            memRead = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= fsIdle;
            pc <= '0;
            held <= 1'b0;
        end else if (redirect) begin
            state <= fsIdle;
            pc <= target;
            held <= 1'b0;
        end else begin
            if (memRead) begin
                pc <= pc + 16'd1;
            end
            if (taken) begin
                held <= 1'b0;
            end
            case (state)
                fsIdle: begin
                    if (memRead) begin
                        state <= fsByteOne;
                    end
                end
                fsByteOne: begin
                    if (lenFirst == 2'd1) begin
                        held <= 1'b1;
                        state <= fsIdle;
                    end else begin
                        state <= fsByteTwo;
                    end
                end
                fsByteTwo: begin
                    if (lenHeld == 2'd2) begin
                        held <= 1'b1;
                        state <= fsIdle;
                    end else begin
                        state <= fsByteThree;
                    end
                end
                default: begin
                    held <= 1'b1;
                    state <= fsIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fsByteOne) begin
            opcode <= memData;
        end
        if (state == fsByteTwo) begin
            second <= memData;
        end
        if (state == fsByteThree) begin
            third <= memData;
        end
    end

    assign instr.valid = held;
    assign instr.opcode = opcode;
    assign instr.second = second;
    assign instr.third = third;
    // pc stops at the byte after the instruction while it is held
    assign instr.nextPc = pc;

endmodule

//--- hw/z8Decode.sv
module z8Decode
    import z8CorePkg::*;
    import z8IsaPkg::*;
(
    instrIf.sink    instr,
    execIf.source   exec,
    input  flagsT   flags,
    input  nibbleT  regPtr,
    output regAddrT rdAddrA,
    input  byteT    rdDataA,
    output regAddrT rdAddrB,
    input  byteT    rdDataB,
    output logic    redirect,
    output addrT    target
);

    nibbleT hi;
    nibbleT lo;
    condT cond;
    logic accept;
    logic isAlu;
    logic condBase;
    logic condTrue;
    regAddrT workDst;

    function automatic regAddrT fullReg(byteT r, nibbleT ptr);
        if (r[7:4] == workingPrefix) begin
            return {ptr, r[3:0]};
        end
        return r;
    endfunction

    assign hi = instr.opcode[7:4];
    assign lo = instr.opcode[3:0];
    assign cond = hi;
    assign workDst = {regPtr, hi};

    // Hold off while execute still owns registers or flags
    assign instr.ready = exec.ready;
    assign accept = instr.valid && exec.ready;

    // Two-operand group is 0 to 7, A and B
    assign isAlu = !hi[3] || hi[3:1] == 3'b101;

    always_comb begin
        case (cond[2:0])
            3'd0:    condBase = 1'b0;
            3'd1:    condBase = flags[flagS] ^ flags[flagV];
            3'd2:    condBase = (flags[flagS] ^ flags[flagV]) | flags[flagZ];
            3'd3:    condBase = flags[flagC] | flags[flagZ];
            3'd4:    condBase = flags[flagV];
            3'd5:    condBase = flags[flagS];
            3'd6:    condBase = flags[flagZ];
            default: condBase = flags[flagC];
        endcase
        condTrue = condBase ^ cond[3];
    end

    always_comb begin
        exec.valid = 1'b0;
        exec.op = opLd;
        exec.a = rdDataA;
        exec.b = rdDataB;
        exec.dst = fullReg(instr.second, regPtr);
        rdAddrA = fullReg(instr.second, regPtr);
        rdAddrB = {regPtr, instr.second[3:0]};
        redirect = 1'b0;
        target = instr.nextPc + {{8{instr.second[7]}}, instr.second};

        case (lo)
            lnRegReg: begin
                if (isAlu) begin
                    exec.valid = accept;
                    exec.op = aluOpT'(hi);
                    exec.dst = {regPtr, instr.second[7:4]};
                    rdAddrA = {regPtr, instr.second[7:4]};
                end
            end
            lnRegImm: begin
                if (isAlu) begin
                    exec.valid = accept;
                    exec.op = aluOpT'(hi);
                    exec.b = instr.third;
                end else if (instr.opcode == codeLdRegImm) begin
                    exec.valid = accept;
                    exec.a = instr.third;
                end
            end
            lnLdRR: begin
                // Source comes in on port A
                exec.valid = accept;
                exec.dst = workDst;
            end
            lnLdImm: begin
                exec.valid = accept;
                exec.a = instr.second;
                exec.dst = workDst;
            end
            lnJr: begin
                redirect = accept && condTrue;
            end
            lnJp: begin
                redirect = accept && condTrue;
                target = {instr.second, instr.third};
            end
            lnMisc: begin
                if (aluOpT'(hi) inside {opRcf, opScf, opCcf}) begin
                    exec.valid = accept;
                    exec.op = aluOpT'(hi);
                end
            end
            default: begin
                // srp is a load into the pointer register
                if (instr.opcode == codeSrp) begin
                    exec.valid = accept;
                    exec.a = instr.second;
                    exec.dst = regPtrAddr;
                end
            end
        endcase
    end

endmodule

//--- hw/z8RegFile.sv
module z8RegFile
    import z8CorePkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rdAddrA,
    output byteT    rdDataA,
    input  regAddrT rdAddrB,
    output byteT    rdDataB,
    input  logic    wbValid,
    input  regAddrT wbAddr,
    input  byteT    wbData,
    output nibbleT  regPtr
);

    byteT regs [0:127];

    function automatic byteT readReg(regAddrT addr, nibbleT ptr, byteT data);
        if (!addr[7]) begin
            return data;
        end
        if (addr == regPtrAddr) begin
            return {ptr, 4'h0};
        end
        return '0;
    endfunction

    assign rdDataA = readReg(rdAddrA, regPtr, regs[rdAddrA[6:0]]);
    assign rdDataB = readReg(rdAddrB, regPtr, regs[rdAddrB[6:0]]);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regPtr <= '0;
        end else if (wbValid && wbAddr == regPtrAddr) begin
            regPtr <= wbData[7:4];
        end
    end

    // General registers 00 to 7F
    always_ff @(posedge clk) begin
        if (wbValid && !wbAddr[7]) begin
            regs[wbAddr[6:0]] <= wbData;
        end
    end

endmodule

//--- hw/z8Execute.sv
module z8Execute
    import z8CorePkg::*;
    import z8IsaPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    execIf.sink     exec,
    output logic    wbValid,
    output regAddrT wbAddr,
    output byteT    wbData,
    output flagsT   flags
);

    logic held;
    aluOpT op;
    byteT a;
    byteT b;
    regAddrT dst;
    byteT result;
    logic [8:0] sum;
    logic carryIn;
    logic isLogic;
    flagsT nextFlags;

    // One item in flight at a time
    assign exec.ready = !held;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            held <= 1'b0;
            flags <= '0;
        end else begin
            held <= exec.valid && !held;
            if (held) begin
                flags <= nextFlags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exec.valid && !held) begin
            op <= exec.op;
            a <= exec.a;
            b <= exec.b;
            dst <= exec.dst;
        end
    end

    assign carryIn = (op == opAdc || op == opSbc) && flags[flagC];
    assign isLogic = op inside {opOr, opAnd, opTcm, opTm, opXor};

    always_comb begin
        sum = '0;
        result = a;
        nextFlags = flags;
        case (op)
            opAdd, opAdc: begin
                sum = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};
                result = sum[7:0];
                nextFlags[flagC] = sum[8];
                nextFlags[flagV] = (a[7] == b[7]) && (result[7] != a[7]);
            end
            opSub, opSbc, opCp: begin
                // Bit 8 is the borrow
                sum = {1'b0, a} - {1'b0, b} - {8'd0, carryIn};
                result = sum[7:0];
                nextFlags[flagC] = sum[8];
                nextFlags[flagV] = (a[7] != b[7]) && (result[7] != a[7]);
            end
            opOr:         result = a | b;
            opAnd, opTm:  result = a & b;
            opTcm:        result = ~a & b;
            opXor:        result = a ^ b;
            opRcf:        nextFlags[flagC] = 1'b0;
            opScf:        nextFlags[flagC] = 1'b1;
            opCcf:        nextFlags[flagC] = ~flags[flagC];
            default:      result = a;
        endcase
        if (isLogic) begin
            nextFlags[flagV] = 1'b0;
        end
        // Z and S for every ALU operation
        if (!(op inside {opLd, opRcf, opScf, opCcf})) begin
            nextFlags[flagZ] = result == 8'd0;
            nextFlags[flagS] = result[7];
        end
    end

    // tcm, tm and cp only touch flags
    assign wbValid = held && (op inside {opAdd, opAdc, opSub, opSbc, opOr, opAnd,
                                         opXor, opLd});
    assign wbAddr = dst;
    assign wbData = result;

endmodule

//--- hw/z8Core.sv
module z8Core
    import z8CorePkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    output addrT       memAddr,
    output logic       memRead,
    input  byteT       memData,
    output logic       wbValid,
    output regAddrT    wbAddr,
    output byteT       wbData,
    output logic [3:0] flags
);

    logic redirect;
    addrT target;
    regAddrT rdAddrA;
    regAddrT rdAddrB;
    byteT rdDataA;
    byteT rdDataB;
    nibbleT regPtr;

    instrIf instrBus();
    execIf execBus();

    z8Fetch i_z8Fetch (
        .clk      (clk),
        .rstN     (rstN),
        .memAddr  (memAddr),
        .memRead  (memRead),
        .memData  (memData),
        .redirect (redirect),
        .target   (target),
        .instr    (instrBus.source)
    );

    z8Decode i_z8Decode (
        .instr    (instrBus.sink),
        .exec     (execBus.source),
        .flags    (flags),
        .regPtr   (regPtr),
        .rdAddrA  (rdAddrA),
        .rdDataA  (rdDataA),
        .rdAddrB  (rdAddrB),
        .rdDataB  (rdDataB),
        .redirect (redirect),
        .target   (target)
    );

    z8RegFile i_z8RegFile (
        .clk      (clk),
        .rstN     (rstN),
        .rdAddrA  (rdAddrA),
        .rdDataA  (rdDataA),
        .rdAddrB  (rdAddrB),
        .rdDataB  (rdDataB),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .regPtr   (regPtr)
    );

    z8Execute i_z8Execute (
        .clk      (clk),
        .rstN     (rstN),
        .exec     (execBus.sink),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .flags    (flags)
    );

endmodule

//--- verif/z8Tests.svh
logic [7:0] prog [$];
logic [15:0] expWb [$];
logic [7:0] skipped [$];
logic [3:0] modelFlags;

task automatic emit(input logic [7:0] b);
    prog.push_back(b);
endtask

task automatic expectWb(input logic [7:0] addr, input logic [7:0] data);
    expWb.push_back({addr, data});
endtask

task automatic startProgram();
    prog.delete();
    expWb.delete();
    skipped.delete();
    modelFlags = 4'h0;
endtask

// Marker load followed by jr always onto itself
task automatic endProgram();
    emit(8'hE6);
    emit(8'h7F);
    emit(8'hA5);
    expectWb(8'h7F, 8'hA5);
    emit(8'h8B);
    emit(8'hFE);
endtask

// Flags are {C, Z, S, V}
function automatic bit condHolds(input logic [3:0] cc, input logic [3:0] f);
    bit base;
    case (cc[2:0])
        3'd0:    base = 1'b0;
        3'd1:    base = f[1] ^ f[0];
        3'd2:    base = (f[1] ^ f[0]) | f[2];
        3'd3:    base = f[3] | f[2];
        3'd4:    base = f[0];
        3'd5:    base = f[1];
        3'd6:    base = f[2];
        default: base = f[3];
    endcase
    return cc[3] ? !base : base;
endfunction

task automatic refAlu(input logic [3:0] code, input logic [7:0] a, input logic [7:0] b,
                      input logic [3:0] fin, output logic [7:0] res,
                      output logic [3:0] fout, output bit writes);
    int cin;
    int u;
    int s;
    cin = (code == 4'h1 || code == 4'h3) ? int'(fin[3]) : 0;
    fout = fin;
    writes = !(code inside {4'h6, 4'h7, 4'hA});
    res = 8'h00;
    case (code)
        4'h0, 4'h1: begin
            u = int'(a) + int'(b) + cin;
            s = int'($signed(a)) + int'($signed(b)) + cin;
            res = u[7:0];
            fout[3] = u > 255;
            fout[0] = s > 127 || s < -128;
        end
        4'h2, 4'h3, 4'hA: begin
            u = int'(a) - int'(b) - cin;
            s = int'($signed(a)) - int'($signed(b)) - cin;
            res = u[7:0];
            fout[3] = u < 0;
            fout[0] = s > 127 || s < -128;
        end
        4'h4: res = a | b;
        4'h5, 4'h7: res = a & b;
        4'h6: res = ~a & b;
        default: res = a ^ b;
    endcase
    if (code inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hB}) begin
        fout[0] = 1'b0;
    end
    fout[2] = res == 8'h00;
    fout[1] = res[7];
endtask

task automatic runProgram(input string name);
    int waited;
    @(posedge clk);
    rstN <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 256; i++) begin
        mem[i] = 8'(i * 7) ^ 8'h5A;
    end
    foreach (prog[i]) begin
        mem[i] = prog[i];
    end
    repeat (9) @(posedge clk);
    wbLog.delete();
    markerSeen = 1'b0;
    rstN <= 1'b1;
    waited = 0;
    while (!markerSeen && waited < 400) begin
        @(posedge clk);
        waited++;
    end
    @(negedge clk);
    if (!markerSeen) begin
        $display("%s: final marker was never written back", name);
        errors++;
    end
    foreach (expWb[i]) begin
        checks++;
        if (i >= wbLog.size()) begin
            $display("%s: writeback %0d (%h) never happened", name, i, expWb[i]);
            errors++;
        end else if (wbLog[i] !== expWb[i]) begin
            $display("MISMATCH %s: writeback %0d expected %h actual %h",
                     name, i, expWb[i], wbLog[i]);
            errors++;
        end
    end
    if (wbLog.size() > expWb.size()) begin
        $display("%s: %0d writebacks more than expected", name,
                 wbLog.size() - expWb.size());
        errors++;
    end
    checks++;
    if (flags !== modelFlags) begin
        $display("MISMATCH %s: flags expected %b actual %b", name, modelFlags, flags);
        errors++;
    end
endtask

task automatic pointerLoads();
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] z;
    x = 8'($urandom);
    y = 8'($urandom);
    z = 8'($urandom);
    startProgram();
    emit(8'h31);
    emit(8'h20);
    expectWb(8'hFD, 8'h20);
    emit(8'h3C);
    emit(x);
    expectWb(8'h23, x);
    emit(8'hE6);
    emit(8'hE5);
    emit(y);
    expectWb(8'h25, y);
    emit(8'hE6);
    emit(8'h10);
    emit(z);
    expectWb(8'h10, z);
    endProgram();
    runProgram("loads");
endtask

// With pointer 3 r0 is register 30
task automatic aluCase(input string name, input logic [3:0] code, input bit useImm);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    logic [3:0] fout;
    bit writes;
    bit cin;
    a = 8'($urandom);
    b = 8'($urandom);
    cin = 1'($urandom);
    startProgram();
    emit(8'h31);
    emit(8'h30);
    expectWb(8'hFD, 8'h30);
    // cp FD,#B0 overflows and sets C, S and V
    emit(8'hA6);
    emit(8'hFD);
    emit(8'hB0);
    refAlu(4'hA, 8'h30, 8'hB0, modelFlags, res, fout, writes);
    modelFlags = fout;
    if (cin) begin
        emit(8'hDF);
    end else begin
        emit(8'hCF);
    end
    modelFlags[3] = cin;
    emit(8'h0C);
    emit(a);
    expectWb(8'h30, a);
    if (useImm) begin
        emit({code, 4'h6});
        emit(8'hE0);
        emit(b);
    end else begin
        emit(8'h1C);
        emit(b);
        expectWb(8'h31, b);
        emit({code, 4'h2});
        emit(8'h01);
    end
    refAlu(code, a, b, modelFlags, res, fout, writes);
    modelFlags = fout;
    if (writes) begin
        expectWb(8'h30, res);
    end
    endProgram();
    runProgram(name);
endtask

task automatic arithmeticOps();
    aluCase("add reg", 4'h0, 1'b0);
    aluCase("add imm", 4'h0, 1'b1);
    aluCase("adc reg", 4'h1, 1'b0);
    aluCase("adc imm", 4'h1, 1'b1);
    aluCase("sub reg", 4'h2, 1'b0);
    aluCase("sub imm", 4'h2, 1'b1);
    aluCase("sbc reg", 4'h3, 1'b0);
    aluCase("sbc imm", 4'h3, 1'b1);
endtask

task automatic logicOps();
    aluCase("or", 4'h4, 1'b0);
    aluCase("and", 4'h5, 1'b1);
    aluCase("xor", 4'hB, 1'b0);
    aluCase("tm", 4'h7, 1'b1);
    aluCase("tcm", 4'h6, 1'b0);
    aluCase("cp", 4'hA, 1'b1);
endtask

// Flag op and jr cc over one load before a load that always runs
task automatic jumpOverLoad(input logic [7:0] flagOp, input logic [3:0] cc,
                            input logic [7:0] addr);
    logic [7:0] data;
    data = 8'($urandom);
    emit(flagOp);
    case (flagOp)
        8'hCF:   modelFlags[3] = 1'b0;
        8'hDF:   modelFlags[3] = 1'b1;
        default: modelFlags[3] = ~modelFlags[3];
    endcase
    emit({cc, 4'hB});
    emit(8'h03);
    emit(8'hE6);
    emit(addr);
    emit(data);
    if (condHolds(cc, modelFlags)) begin
        skipped.push_back(addr);
    end else begin
        expectWb(addr, data);
    end
    emit(8'hE6);
    emit(8'(addr + 1));
    emit(~data);
    expectWb(8'(addr + 1), ~data);
endtask

task automatic flagOpJumps();
    startProgram();
    jumpOverLoad(8'hDF, 4'h7, 8'h50);
    jumpOverLoad(8'hCF, 4'hF, 8'h52);
    jumpOverLoad(8'hEF, 4'hF, 8'h54);
    jumpOverLoad(8'hDF, 4'h7, 8'h56);
    endProgram();
    runProgram("flag jumps");
    foreach (skipped[i]) begin
        foreach (wbLog[j]) begin
            if (wbLog[j][15:8] == skipped[i]) begin
                $display("flag jumps: load to %h ran although its jump was taken",
                         skipped[i]);
                errors++;
            end
        end
    end
endtask

task automatic absoluteJumps();
    logic [7:0] v;
    startProgram();
    v = 8'($urandom);
    emit(8'h31);
    emit(8'h20);
    expectWb(8'hFD, 8'h20);
    emit(8'h4C);
    emit(v);
    expectWb(8'h24, v);
    // jp f is never taken
    emit(8'h0D);
    emit(8'h00);
    emit(8'(prog.size() + 4));
    emit(8'hE6);
    emit(8'h60);
    emit(8'h01);
    if (!condHolds(4'h0, modelFlags)) begin
        expectWb(8'h60, 8'h01);
    end
    // jp ugt past the next load
    emit(8'hBD);
    emit(8'h00);
    emit(8'(prog.size() + 4));
    emit(8'hE6);
    emit(8'h61);
    emit(8'h02);
    if (!condHolds(4'hB, modelFlags)) begin
        expectWb(8'h61, 8'h02);
    end
    // ld r5,E4 copies register 24 into 25
    emit(8'h58);
    emit(8'hE4);
    expectWb(8'h25, v);
    endProgram();
    runProgram("absolute jumps");
endtask

//--- verif/z8CoreTb.sv
module z8CoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycleLimit = 4000;

    logic clk;
    logic rstN;
    logic [15:0] memAddr;
    logic memRead;
    logic [7:0] memData;
    logic wbValid;
    logic [7:0] wbAddr;
    logic [7:0] wbData;
    logic [3:0] flags;

    logic [7:0] mem [0:255];
    logic [15:0] wbLog [$];
    logic markerSeen;
    int errors;
    int checks;
    int cycles = 0;

    z8Core i_z8Core (
        .clk     (clk),
        .rstN    (rstN),
        .memAddr (memAddr),
        .memRead (memRead),
        .memData (memData),
        .wbValid (wbValid),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .flags   (flags)
    );

    `include "z8Tests.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Synchronous byte memory answering one cycle after the request
    always @(posedge clk) begin
        if (memRead) begin
            memData <= mem[memAddr[7:0]];
        end
    end

    // Writeback monitor
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            wbLog.push_back({wbAddr, wbData});
            if (wbAddr == 8'h7F && wbData == 8'hA5) begin
                markerSeen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        memData = 8'h00;
        errors = 0;
        checks = 0;
        markerSeen = 1'b0;
        void'($urandom(2473));
        pointerLoads();
        arithmeticOps();
        logicOps();
        flagOpJumps();
        absoluteJumps();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verif
hw/z8CorePkg.sv
hw/z8IsaPkg.sv
hw/z8StageIf.sv
hw/z8Fetch.sv
hw/z8Decode.sv
hw/z8RegFile.sv
hw/z8Execute.sv
hw/z8Core.sv
verif/z8CoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = z8CoreTb
FILELIST  = files.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST)) verif/z8Tests.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
